// ==== vga_game_top.f ====
verilog/vga_pkg.sv
verilog/vga_timing.sv
verilog/draw_bg.sv
verilog/game_screen.sv
verilog/game_ctrl.sv
verilog/vga_game_top.sv
sim/vga_game_properties.sv
sim/vga_game_tb.sv

// ==== sim/vga_game_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module vga_game_tb;
    import vga_pkg::*;

    localparam int H_VIS        = 440;
    localparam int V_VIS        = 300;
    localparam int H_TOT        = 480;
    localparam int V_TOT        = 320;
    localparam int HS_START     = 450;
    localparam int HS_LEN       = 10;
    localparam int VS_START     = 305;
    localparam int VS_LEN       = 2;
    localparam int BOX_X        = H_VIS / 4;
    localparam int BOX_Y        = V_VIS / 3;
    localparam int BOX_W        = H_VIS / 2;
    localparam int BOX_H        = V_VIS / 3;
    localparam int FRAME_CYCLES = H_TOT * V_TOT;

    logic             clk;
    logic             rst;
    logic             psel;
    logic             penable;
    logic             pwrite;
    logic [3:0]       paddr;
    logic [31:0]      pwdata;
    wire  [31:0]      prdata;
    wire              pready;
    wire              pslverr;
    wire  [CNT_W-1:0] hcount;
    wire  [CNT_W-1:0] vcount;
    wire              hsync;
    wire              vsync;
    wire              hblnk;
    wire              vblnk;
    wire  [RGB_W-1:0] rgb;

    // last sampled output pixel
    int               s_h;
    int               s_v;
    logic             s_hs;
    logic             s_vs;
    logic             s_hb;
    logic             s_vb;
    logic [RGB_W-1:0] s_rgb;

    // expected register contents, kept by the testbench
    logic [1:0]       exp_state;
    logic [1:0]       exp_pend;
    logic             exp_pend_valid;
    logic [RGB_W-1:0] exp_bg;
    int               seed;

    vga_game_top #(
        .HOR_TOTAL   (H_TOT),
        .VER_TOTAL   (V_TOT),
        .HOR_PIXELS  (H_VIS),
        .VER_PIXELS  (V_VIS),
        .HSYNC_START (HS_START),
        .HSYNC_LEN   (HS_LEN),
        .VSYNC_START (VS_START),
        .VSYNC_LEN   (VS_LEN)
    ) dut (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .hcount  (hcount),
        .vcount  (vcount),
        .hsync   (hsync),
        .vsync   (vsync),
        .hblnk   (hblnk),
        .vblnk   (vblnk),
        .rgb     (rgb)
    );

    always #50 clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("ERROR: %s is 0x%0h, expected 0x%0h", name, actual, expected));
        end
    endtask

    // inclusive rectangle test in box coordinates
    function automatic logic in_rect(input int x, input int y, input int x0, input int x1,
                                     input int y0, input int y1);
        return (x >= x0) && (x <= x1) && (y >= y0) && (y <= y1);
    endfunction

    function automatic logic [RGB_W-1:0] expected_rgb(input int h, input int v,
                                                      input logic [1:0] state,
                                                      input logic [RGB_W-1:0] bg);
        int   rx;
        int   ry;
        logic hit;
        if (h >= H_VIS || v >= V_VIS) begin
            return 12'h000;
        end
        rx = h - BOX_X;
        ry = v - BOX_Y;
        if (rx < 0 || rx >= BOX_W || ry < 0 || ry >= BOX_H || state == GAME_PLAY) begin
            return bg;
        end
        if (state == GAME_START) begin
            hit = in_rect(rx, ry, 20, 49, 20, 29) || in_rect(rx, ry, 20, 29, 30, 59) ||
                  in_rect(rx, ry, 20, 49, 60, 69) || in_rect(rx, ry, 40, 49, 70, 99) ||
                  in_rect(rx, ry, 60, 99, 20, 29) || in_rect(rx, ry, 80, 89, 30, 99) ||
                  in_rect(rx, ry, 110, 119, 30, 99) || in_rect(rx, ry, 140, 149, 30, 99) ||
                  in_rect(rx, ry, 120, 139, 50, 59) || in_rect(rx, ry, 160, 169, 30, 99) ||
                  in_rect(rx, ry, 170, 199, 30, 39) || in_rect(rx, ry, 200, 209, 40, 59) ||
                  in_rect(rx, ry, 170, 199, 60, 69) || in_rect(rx, ry, 200, 209, 70, 99);
        end else begin
            hit = in_rect(rx, ry, 30, 39, 30, 99) || in_rect(rx, ry, 30, 69, 30, 39) ||
                  in_rect(rx, ry, 30, 59, 60, 69) || in_rect(rx, ry, 30, 69, 90, 99) ||
                  in_rect(rx, ry, 80, 89, 30, 99) || in_rect(rx, ry, 80, 139, 30, 39) ||
                  in_rect(rx, ry, 130, 139, 30, 99) || in_rect(rx, ry, 150, 159, 30, 99) ||
                  in_rect(rx, ry, 150, 189, 30, 39) || in_rect(rx, ry, 190, 199, 40, 89) ||
                  in_rect(rx, ry, 150, 189, 90, 99);
        end
        return hit ? 12'hFF0 : 12'h000;
    endfunction

    task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        int n;
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;
        n = 0;
        @(negedge clk);
        while (!pready) begin
            n++;
            if (n > 16) abort_run("APB transfer never saw pready");
            else @(negedge clk);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, output logic err);
        logic [31:0] unused;
        apb_access(1'b1, addr, data, unused, err);
        if (addr == REG_CTRL && data < 3) begin
            exp_pend       = data[1:0];
            exp_pend_valid = 1'b1;
        end
        if (addr == REG_BG_COLOR) begin
            exp_bg = data[RGB_W-1:0];
        end
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data, output logic err);
        apb_access(1'b0, addr, 32'd0, data, err);
    endtask

    task automatic next_pixel();
        @(posedge clk);
        #1;
        s_h   = hcount;
        s_v   = vcount;
        s_hs  = hsync;
        s_vs  = vsync;
        s_hb  = hblnk;
        s_vb  = vblnk;
        s_rgb = rgb;
        // a pending state shows from the first pixel of the new frame
        if (s_h == 0 && s_v == 0 && exp_pend_valid) begin
            exp_state      = exp_pend;
            exp_pend_valid = 1'b0;
        end
    endtask

    task automatic wait_pixel(input int h, input int v);
        int n;
        n = 0;
        next_pixel();
        while (s_h != h || s_v != v) begin
            n++;
            if (n > FRAME_CYCLES + 8) abort_run($sformatf("timeout waiting for pixel %0d,%0d", h, v));
            else next_pixel();
        end
    endtask

    task automatic wait_frame();
        wait_pixel(0, 0);
    endtask

    task automatic check_pixel();
        check("rgb", s_rgb, expected_rgb(s_h, s_v, exp_state, exp_bg));
        check("hsync", s_hs, (s_h >= HS_START) && (s_h < HS_START + HS_LEN));
        check("vsync", s_vs, (s_v >= VS_START) && (s_v < VS_START + VS_LEN));
        check("hblnk", s_hb, s_h >= H_VIS);
        check("vblnk", s_vb, s_v >= V_VIS);
    endtask

    // checks every pixel up to the last one of the frame, along with the raster order
    task automatic scan_rest_of_frame(output int count);
        int ph;
        int pv;
        int eh;
        int ev;
        ph = s_h;
        pv = s_v;
        count = 0;
        while (ph != H_TOT - 1 || pv != V_TOT - 1) begin
            if (count > FRAME_CYCLES) abort_run("frame scan did not reach the last pixel");
            else next_pixel();
            eh = (ph == H_TOT - 1) ? 0 : ph + 1;
            ev = (ph != H_TOT - 1) ? pv : ((pv == V_TOT - 1) ? 0 : pv + 1);
            check("hcount", s_h, eh);
            check("vcount", s_v, ev);
            check_pixel();
            ph = s_h;
            pv = s_v;
            count++;
        end
    endtask

    task automatic test_reset_values();
        logic [31:0] data;
        logic        err;
        int          n;
        apb_read(REG_STATUS, data, err);
        check("pslverr", err, 1'b0);
        check("prdata", data, 32'h0);
        wait_pixel(10, 10);
        check("rgb", s_rgb, 12'h00F);
        wait_pixel(BOX_X + 5, BOX_Y + 5);
        check("rgb", s_rgb, 12'h000);
        wait_pixel(BOX_X + 20, BOX_Y + 20);
        check("rgb", s_rgb, 12'hFF0);
        wait_pixel(BOX_X + 25, BOX_Y + 45);
        check("rgb", s_rgb, 12'hFF0);
        wait_frame();
        check_pixel();
        scan_rest_of_frame(n);
    endtask

    task automatic test_scan_geometry();
        int n;
        wait_frame();
        check_pixel();
        scan_rest_of_frame(n);
        check("pixels per frame", n + 1, FRAME_CYCLES);
    endtask

    task automatic test_state_change();
        logic [31:0] data;
        logic        err;
        int          n;
        wait_pixel(0, 150);
        apb_write(REG_CTRL, GAME_PLAY, err);
        check("pslverr", err, 1'b0);
        apb_read(REG_STATUS, data, err);
        check("prdata", data, 32'h4);
        next_pixel();
        check_pixel();
        scan_rest_of_frame(n);
        wait_frame();
        check("rgb", s_rgb, 12'h00F);
        check_pixel();
        scan_rest_of_frame(n);
        apb_read(REG_STATUS, data, err);
        check("prdata", data, 32'h1);
    endtask

    task automatic test_end_screen();
        logic [31:0]      data;
        logic             err;
        logic [RGB_W-1:0] color;
        int               skip;
        logic             done;
        wait_pixel(0, 150);
        color = $urandom & 12'hFFF;
        apb_write(REG_BG_COLOR, color, err);
        apb_write(REG_CTRL, GAME_END, err);
        wait_frame();
        check_pixel();
        done = 1'b0;
        for (int i = 0; i < 300 && !done; i++) begin
            skip = ($urandom % 400) + 1;
            for (int k = 0; k < skip && !done; k++) begin
                next_pixel();
                done = (s_h == H_TOT - 1) && (s_v == V_TOT - 1);
            end
            check_pixel();
        end
        wait_pixel(5, 5);
        check("rgb", s_rgb, color);
        wait_pixel(BOX_X + 30, BOX_Y + 30);
        check("rgb", s_rgb, 12'hFF0);
        wait_pixel(BOX_X + 45, BOX_Y + 45);
        check("rgb", s_rgb, 12'h000);
        apb_read(REG_STATUS, data, err);
        check("prdata", data, 32'h2);
    endtask

    task automatic test_apb_errors();
        logic [31:0]      data;
        logic             err;
        logic [RGB_W-1:0] color;
        apb_read(4'hC, data, err);
        check("pslverr", err, 1'b1);
        check("prdata", data, 32'h0);
        apb_write(4'hC, 32'hFFFF_FFFF, err);
        check("pslverr", err, 1'b1);
        apb_read(REG_BG_COLOR, data, err);
        check("pslverr", err, 1'b0);
        check("prdata", data, exp_bg);
        apb_write(REG_CTRL, 32'd3, err);
        check("pslverr", err, 1'b0);
        apb_read(REG_CTRL, data, err);
        check("prdata", data, exp_pend);
        apb_read(REG_STATUS, data, err);
        check("prdata", data, {exp_pend_valid, exp_state});
        color = $urandom & 12'hFFF;
        apb_write(REG_BG_COLOR, color, err);
        apb_read(REG_BG_COLOR, data, err);
        check("prdata", data, color);
    endtask

    initial begin
        seed           = $urandom(49305);
        clk            = 1'b0;
        rst            = 1'b1;
        psel           = 1'b0;
        penable        = 1'b0;
        pwrite         = 1'b0;
        paddr          = '0;
        pwdata         = '0;
        exp_state      = GAME_START;
        exp_pend       = GAME_START;
        exp_pend_valid = 1'b0;
        exp_bg         = 12'h00F;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        test_reset_values();
        test_scan_geometry();
        test_state_change();
        test_end_screen();
        test_apb_errors();
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/vga_game_properties.sv ====
`timescale 1ns/100ps
`default_nettype none

module vga_game_properties #(
    parameter int HOR_TOTAL = vga_pkg::HOR_TOTAL
) (
    input wire                          clk,
    input wire                          rst,
    input wire                          psel,
    input wire                          penable,
    input wire  [3:0]                   paddr,
    input wire                          pslverr,
    input wire                          hblnk,
    input wire                          vblnk,
    input wire  [vga_pkg::RGB_W-1:0]    rgb,
    input wire  [vga_pkg::CNT_W-1:0]    hcount,
    input wire                          frame_start,
    input wire  vga_pkg::game_state_t   game_state
);

    // only an access cycle to an offset other than 0x0, 0x4 and 0x8 may raise an error
    a_pslverr_decode: assert property (@(posedge clk) disable iff (rst)
        pslverr == (psel && penable &&
                    (paddr != 4'h0) && (paddr != 4'h4) && (paddr != 4'h8)))
        else $error("pslverr does not match the APB access cycle and offset");

    a_black_in_blanking: assert property (@(posedge clk) disable iff (rst)
        (hblnk || vblnk) |-> (rgb == '0))
        else $error("rgb not black during blanking");

    a_hcount_range: assert property (@(posedge clk) disable iff (rst)
        hcount < HOR_TOTAL)
        else $error("hcount reached the horizontal total");

    // the displayed state may only move right after the frame boundary
    a_state_on_frame: assert property (@(posedge clk) disable iff (rst)
        (game_state != $past(game_state)) |-> $past(frame_start))
        else $error("game_state changed away from a frame boundary");

endmodule

bind vga_game_top vga_game_properties #(
    .HOR_TOTAL (HOR_TOTAL)
) u_properties (
    .clk         (clk),
    .rst         (rst),
    .psel        (psel),
    .penable     (penable),
    .paddr       (paddr),
    .pslverr     (pslverr),
    .hblnk       (hblnk),
    .vblnk       (vblnk),
    .rgb         (rgb),
    .hcount      (hcount),
    .frame_start (frame_start),
    .game_state  (game_state)
);

`default_nettype wire

// ==== verilog/vga_game_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module vga_game_top #(
    parameter int HOR_TOTAL   = vga_pkg::HOR_TOTAL,
    parameter int VER_TOTAL   = vga_pkg::VER_TOTAL,
    parameter int HOR_PIXELS  = vga_pkg::HOR_PIXELS,
    parameter int VER_PIXELS  = vga_pkg::VER_PIXELS,
    parameter int HSYNC_START = vga_pkg::HSYNC_START,
    parameter int HSYNC_LEN   = vga_pkg::HSYNC_LEN,
    parameter int VSYNC_START = vga_pkg::VSYNC_START,
    parameter int VSYNC_LEN   = vga_pkg::VSYNC_LEN
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          psel,
    input  wire                          penable,
    input  wire                          pwrite,
    input  wire  [3:0]                   paddr,
    input  wire  [31:0]                  pwdata,
    output logic [31:0]                  prdata,
    output logic                         pready,
    output logic                         pslverr,
    output logic [vga_pkg::CNT_W-1:0]    hcount,
    output logic [vga_pkg::CNT_W-1:0]    vcount,
    output logic                         hsync,
    output logic                         vsync,
    output logic                         hblnk,
    output logic                         vblnk,
    output logic [vga_pkg::RGB_W-1:0]    rgb
);
    import vga_pkg::*;

    game_state_t      game_state;
    logic [RGB_W-1:0] bg_color;
    logic             frame_start;

    // timing stage outputs
    logic [CNT_W-1:0] tim_hcount;
    logic [CNT_W-1:0] tim_vcount;
    logic             tim_hsync;
    logic             tim_vsync;
    logic             tim_hblnk;
    logic             tim_vblnk;

    // background stage outputs
    logic [CNT_W-1:0] bg_hcount;
    logic [CNT_W-1:0] bg_vcount;
    logic             bg_hsync;
    logic             bg_vsync;
    logic             bg_hblnk;
    logic             bg_vblnk;
    logic [RGB_W-1:0] bg_rgb;

    game_ctrl u_game_ctrl (
        .clk         (clk),
        .rst         (rst),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .frame_start (frame_start),
        .game_state  (game_state),
        .bg_color    (bg_color)
    );

    vga_timing #(
        .HOR_TOTAL   (HOR_TOTAL),
        .VER_TOTAL   (VER_TOTAL),
        .HOR_PIXELS  (HOR_PIXELS),
        .VER_PIXELS  (VER_PIXELS),
        .HSYNC_START (HSYNC_START),
        .HSYNC_LEN   (HSYNC_LEN),
        .VSYNC_START (VSYNC_START),
        .VSYNC_LEN   (VSYNC_LEN)
    ) u_vga_timing (
        .clk         (clk),
        .rst         (rst),
        .hcount      (tim_hcount),
        .vcount      (tim_vcount),
        .hsync       (tim_hsync),
        .vsync       (tim_vsync),
        .hblnk       (tim_hblnk),
        .vblnk       (tim_vblnk),
        .frame_start (frame_start)
    );

    draw_bg u_draw_bg (
        .clk       (clk),
        .rst       (rst),
        .hcount_in (tim_hcount),
        .vcount_in (tim_vcount),
        .hsync_in  (tim_hsync),
        .vsync_in  (tim_vsync),
        .hblnk_in  (tim_hblnk),
        .vblnk_in  (tim_vblnk),
        .bg_color  (bg_color),
        .hcount    (bg_hcount),
        .vcount    (bg_vcount),
        .hsync     (bg_hsync),
        .vsync     (bg_vsync),
        .hblnk     (bg_hblnk),
        .vblnk     (bg_vblnk),
        .rgb       (bg_rgb)
    );

    game_screen #(
        .HOR_PIXELS (HOR_PIXELS),
        .VER_PIXELS (VER_PIXELS)
    ) u_game_screen (
        .clk        (clk),
        .rst        (rst),
        .game_state (game_state),
        .hcount_in  (bg_hcount),
        .vcount_in  (bg_vcount),
        .hsync_in   (bg_hsync),
        .vsync_in   (bg_vsync),
        .hblnk_in   (bg_hblnk),
        .vblnk_in   (bg_vblnk),
        .rgb_in     (bg_rgb),
        .hcount     (hcount),
        .vcount     (vcount),
        .hsync      (hsync),
        .vsync      (vsync),
        .hblnk      (hblnk),
        .vblnk      (vblnk),
        .rgb        (rgb)
    );

endmodule

`default_nettype wire

// ==== verilog/game_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module game_ctrl (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          psel,
    input  wire                          penable,
    input  wire                          pwrite,
    input  wire  [3:0]                   paddr,
    input  wire  [31:0]                  pwdata,
    output logic [31:0]                  prdata,
    output logic                         pready,
    output logic                         pslverr,
    input  wire                          frame_start,
    output vga_pkg::game_state_t         game_state,
    output logic [vga_pkg::RGB_W-1:0]    bg_color
);
    import vga_pkg::*;

    localparam logic [RGB_W-1:0] BG_RESET = 12'h00F;

    game_state_t pend_state;
    logic        pend_valid;
    logic        access;
    logic        wr_en;
    logic        addr_ok;
    logic [31:0] rd_data;

    // there are no wait states, so every transfer finishes in its access cycle
    assign pready = 1'b1;
    assign access = psel && penable;
    assign wr_en  = access && pwrite;

    always_comb begin
        addr_ok = 1'b1;
        rd_data = '0;
        case (paddr)
            REG_CTRL:     rd_data = {30'd0, pend_state};
            REG_STATUS:   rd_data = {29'd0, pend_valid, game_state};
            REG_BG_COLOR: rd_data = {{(32 - RGB_W){1'b0}}, bg_color};
            default:      addr_ok = 1'b0;
        endcase
    end

    assign prdata  = (psel && !pwrite) ? rd_data : '0;
    assign pslverr = access && !addr_ok;

    always_ff @(posedge clk) begin
        if (rst) begin
            game_state <= GAME_START;
            pend_state <= GAME_START;
            pend_valid <= 1'b0;
            bg_color   <= BG_RESET;
        end else begin
            // the displayed state only moves at the frame boundary
            if (frame_start && pend_valid) begin
                game_state <= pend_state;
                pend_valid <= 1'b0;
            end
            // a request landing on the boundary waits for the next frame
            if (wr_en && paddr == REG_CTRL && pwdata < 32'd3) begin
                pend_state <= game_state_t'(pwdata[1:0]);
                pend_valid <= 1'b1;
            end
            if (wr_en && paddr == REG_BG_COLOR) begin
                bg_color <= pwdata[RGB_W-1:0];
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/game_screen.sv ====
`timescale 1ns/100ps
`default_nettype none

module game_screen #(
    parameter int HOR_PIXELS = vga_pkg::HOR_PIXELS,
    parameter int VER_PIXELS = vga_pkg::VER_PIXELS
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire  vga_pkg::game_state_t   game_state,
    input  wire  [vga_pkg::CNT_W-1:0]    hcount_in,
    input  wire  [vga_pkg::CNT_W-1:0]    vcount_in,
    input  wire                          hsync_in,
    input  wire                          vsync_in,
    input  wire                          hblnk_in,
    input  wire                          vblnk_in,
    input  wire  [vga_pkg::RGB_W-1:0]    rgb_in,
    output logic [vga_pkg::CNT_W-1:0]    hcount,
    output logic [vga_pkg::CNT_W-1:0]    vcount,
    output logic                         hsync,
    output logic                         vsync,
    output logic                         hblnk,
    output logic                         vblnk,
    output logic [vga_pkg::RGB_W-1:0]    rgb
);
    import vga_pkg::*;

    localparam int BOX_X = HOR_PIXELS / 4;
    localparam int BOX_Y = VER_PIXELS / 3;
    localparam int BOX_W = HOR_PIXELS / 2;
    localparam int BOX_H = VER_PIXELS / 3;

    logic [CNT_W-1:0] rx;
    logic [CNT_W-1:0] ry;
    logic             in_box;
    logic             start_hit;
    logic             end_hit;
    logic [RGB_W-1:0] rgb_nxt;

    // x0..x1 and y0..y1 are half-open, relative to the box corner
    function automatic logic stroke(input logic [CNT_W-1:0] x, input logic [CNT_W-1:0] y,
                                    input int x0, input int x1, input int y0, input int y1);
        return (x >= x0) && (x < x1) && (y >= y0) && (y < y1);
    endfunction

    assign rx = hcount_in - CNT_W'(BOX_X);
    assign ry = vcount_in - CNT_W'(BOX_Y);
    assign in_box = (hcount_in >= BOX_X) && (hcount_in < BOX_X + BOX_W) &&
                    (vcount_in >= BOX_Y) && (vcount_in < BOX_Y + BOX_H);

    // letters S, T, A, R
    assign start_hit = stroke(rx, ry, 20, 50, 20, 30) | stroke(rx, ry, 20, 30, 30, 60) |
                       stroke(rx, ry, 20, 50, 60, 70) | stroke(rx, ry, 40, 50, 70, 100) |
                       stroke(rx, ry, 60, 100, 20, 30) | stroke(rx, ry, 80, 90, 30, 100) |
                       stroke(rx, ry, 110, 120, 30, 100) | stroke(rx, ry, 140, 150, 30, 100) |
                       stroke(rx, ry, 120, 140, 50, 60) |
                       stroke(rx, ry, 160, 170, 30, 100) | stroke(rx, ry, 170, 200, 30, 40) |
                       stroke(rx, ry, 200, 210, 40, 60) | stroke(rx, ry, 170, 200, 60, 70) |
                       stroke(rx, ry, 200, 210, 70, 100);

    // letters E, N, D
    assign end_hit = stroke(rx, ry, 30, 40, 30, 100) | stroke(rx, ry, 30, 70, 30, 40) |
                     stroke(rx, ry, 30, 60, 60, 70) | stroke(rx, ry, 30, 70, 90, 100) |
                     stroke(rx, ry, 80, 90, 30, 100) | stroke(rx, ry, 80, 140, 30, 40) |
                     stroke(rx, ry, 130, 140, 30, 100) |
                     stroke(rx, ry, 150, 160, 30, 100) | stroke(rx, ry, 150, 190, 30, 40) |
                     stroke(rx, ry, 190, 200, 40, 90) | stroke(rx, ry, 150, 190, 90, 100);

    always_comb begin
        rgb_nxt = rgb_in;
        if (in_box && game_state == GAME_START) begin
            rgb_nxt = start_hit ? COLOR_YELLOW : COLOR_BLACK;
        end else if (in_box && game_state == GAME_END) begin
            rgb_nxt = end_hit ? COLOR_YELLOW : COLOR_BLACK;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hcount <= '0;
            vcount <= '0;
            hsync  <= 1'b0;
            vsync  <= 1'b0;
            hblnk  <= 1'b0;
            vblnk  <= 1'b0;
            rgb    <= '0;
        end else begin
            hcount <= hcount_in;
            vcount <= vcount_in;
            hsync  <= hsync_in;
            vsync  <= vsync_in;
            hblnk  <= hblnk_in;
            vblnk  <= vblnk_in;
            rgb    <= rgb_nxt;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/draw_bg.sv ====
`timescale 1ns/100ps
`default_nettype none

module draw_bg (
    input  wire                          clk,
    input  wire                          rst,
    input  wire  [vga_pkg::CNT_W-1:0]    hcount_in,
    input  wire  [vga_pkg::CNT_W-1:0]    vcount_in,
    input  wire                          hsync_in,
    input  wire                          vsync_in,
    input  wire                          hblnk_in,
    input  wire                          vblnk_in,
    input  wire  [vga_pkg::RGB_W-1:0]    bg_color,
    output logic [vga_pkg::CNT_W-1:0]    hcount,
    output logic [vga_pkg::CNT_W-1:0]    vcount,
    output logic                         hsync,
    output logic                         vsync,
    output logic                         hblnk,
    output logic                         vblnk,
    output logic [vga_pkg::RGB_W-1:0]    rgb
);
    import vga_pkg::*;

    always_ff @(posedge clk) begin
        if (rst) begin
            hcount <= '0;
            vcount <= '0;
            hsync  <= 1'b0;
            vsync  <= 1'b0;
            hblnk  <= 1'b0;
            vblnk  <= 1'b0;
            rgb    <= '0;
        end else begin
            hcount <= hcount_in;
            vcount <= vcount_in;
            hsync  <= hsync_in;
            vsync  <= vsync_in;
            hblnk  <= hblnk_in;
            vblnk  <= vblnk_in;
            // the monitor expects black in the porches and sync
            rgb    <= (hblnk_in || vblnk_in) ? COLOR_BLACK : bg_color;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/vga_timing.sv ====
`timescale 1ns/100ps
`default_nettype none

module vga_timing #(
    parameter int HOR_TOTAL   = vga_pkg::HOR_TOTAL,
    parameter int VER_TOTAL   = vga_pkg::VER_TOTAL,
    parameter int HOR_PIXELS  = vga_pkg::HOR_PIXELS,
    parameter int VER_PIXELS  = vga_pkg::VER_PIXELS,
    parameter int HSYNC_START = vga_pkg::HSYNC_START,
    parameter int HSYNC_LEN   = vga_pkg::HSYNC_LEN,
    parameter int VSYNC_START = vga_pkg::VSYNC_START,
    parameter int VSYNC_LEN   = vga_pkg::VSYNC_LEN
) (
    input  wire                          clk,
    input  wire                          rst,
    output logic [vga_pkg::CNT_W-1:0]    hcount,
    output logic [vga_pkg::CNT_W-1:0]    vcount,
    output logic                         hsync,
    output logic                         vsync,
    output logic                         hblnk,
    output logic                         vblnk,
    output logic                         frame_start
);
    import vga_pkg::*;

    logic line_end;
    logic frame_end;

    assign line_end  = (hcount == CNT_W'(HOR_TOTAL - 1));
    assign frame_end = (vcount == CNT_W'(VER_TOTAL - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            hcount <= '0;
            vcount <= '0;
        end else if (line_end) begin
            hcount <= '0;
            if (frame_end) begin
                vcount <= '0;
            end else begin
                vcount <= vcount + 1'b1;
            end
        end else begin
            hcount <= hcount + 1'b1;
        end
    end

    // everything below decodes the registered counts, so it lines up with them
    assign hblnk = (hcount >= HOR_PIXELS);
    assign vblnk = (vcount >= VER_PIXELS);
    assign hsync = (hcount >= HSYNC_START) && (hcount < HSYNC_START + HSYNC_LEN);
    assign vsync = (vcount >= VSYNC_START) && (vcount < VSYNC_START + VSYNC_LEN);

    // high only while the counters sit at the top left pixel
    assign frame_start = (hcount == '0) && (vcount == '0);

endmodule

`default_nettype wire

// ==== verilog/vga_pkg.sv ====
`default_nettype none

package vga_pkg;

    // default SVGA 800x600 timing
    localparam int HOR_PIXELS  = 800;
    localparam int VER_PIXELS  = 600;
    localparam int HOR_TOTAL   = 1056;
    localparam int VER_TOTAL   = 628;
    localparam int HSYNC_START = 840;
    localparam int HSYNC_LEN   = 128;
    localparam int VSYNC_START = 601;
    localparam int VSYNC_LEN   = 4;

    localparam int CNT_W = 11;
    localparam int RGB_W = 12;

    localparam logic [RGB_W-1:0] COLOR_BLACK  = 12'h000;
    localparam logic [RGB_W-1:0] COLOR_YELLOW = 12'hFF0;

    typedef enum logic [1:0] {
        GAME_START = 2'd0,
        GAME_PLAY  = 2'd1,
        GAME_END   = 2'd2
    } game_state_t;

    // byte offsets of the APB registers
    typedef enum logic [3:0] {
        REG_CTRL     = 4'h0,
        REG_STATUS   = 4'h4,
        REG_BG_COLOR = 4'h8
    } apb_reg_t;

endpackage

`default_nettype wire
